// ==== files.f ====
source/soc_pkg.sv
source/bus_ctrl.sv
source/rom_block.sv
source/ram_block.sv
source/periph_regs.sv
source/kbd_queue.sv
source/soc_fabric.sv
test/soc_fabric_properties.sv
test/tb_soc_fabric.sv

// ==== run.sh ====
#!/bin/sh
# Build the bus fabric testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_soc_fabric -o sim_tb_soc_fabric
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_soc_fabric)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1

// ==== source/rom_init.hex ====
// One 32-bit ROM word per line, starting at word 0
C0DE0000
C0DE0001
C0DE0002
C0DE0003
C0DE0004
C0DE0005
C0DE0006
C0DE0007
C0DE0008
C0DE0009
C0DE000A
C0DE000B
C0DE000C
C0DE000D
C0DE000E
C0DE000F

// ==== test/tb_soc_fabric.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the bus fabric, run from the root
// Drives the req/ack bus and the keyboard and USB inputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_soc_fabric import soc_pkg::*; ();

    // Upper bound on bus accesses over all tests
    localparam int MAX_ACCESSES      = 160;
    localparam int CYCLES_PER_ACCESS = 20;
    localparam int MARGIN_CYCLES     = 200;
    localparam int WATCHDOG_NS = (MAX_ACCESSES * CYCLES_PER_ACCESS + MARGIN_CYCLES) * 10;
    localparam int ACK_LIMIT = 16;

    localparam addr_t DISPLAY_ADDR   = 32'h2000_1000;
    localparam addr_t USB_VALID_ADDR = 32'h2000_4000;
    localparam addr_t USB_HIGH_ADDR  = 32'h2000_4004;
    localparam addr_t USB_LOW_ADDR   = 32'h2000_4008;
    localparam addr_t KBD_STATUS_ADDR = 32'h2000_5000;
    localparam addr_t KBD_CODE_ADDR   = 32'h2000_5004;

    logic        clk;
    logic        reset_i;
    logic        bus_req_i;
    addr_t       bus_addr_i;
    logic        bus_we_i;
    word_t       bus_wdata_i;
    wmask_t      bus_wmask_i;
    logic        bus_ack_o;
    word_t       bus_rdata_o;
    byte_t       kbd_code_i;
    logic        kbd_strobe_i;
    usb_report_t usb_report_i;
    logic        usb_report_valid_i;
    byte_t       display_o;

    logic [31:0] lfsr_state = 32'hd233d763;
    int          errors = 0;
    int          checks = 0;
    int          failed_tests = 0;
    int          last_latency;

    soc_fabric i_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t random_bits(input int n);
        word_t bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic addr_t ram_addr(input logic [9:0] word_addr);
        return {20'h10000, word_addr, 2'b00};
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        assert (got == exp) else begin
            $display("FAILED %0t ns: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Entered just after a rising edge; leaves with ack seen low again
    task automatic bus_access(input addr_t addr, input logic we, input word_t wdata,
                              input wmask_t mask, output word_t rdata);
        int cycles;
        cycles = 0;
        bus_addr_i  <= addr;
        bus_we_i    <= we;
        bus_wdata_i <= wdata;
        bus_wmask_i <= mask;
        bus_req_i   <= 1'b1;
        do begin
            @(posedge clk);
            cycles++;
        end while (!bus_ack_o && cycles < ACK_LIMIT);
        rdata = bus_rdata_o;
        // First edge only samples the request
        last_latency = cycles - 1;
        assert (bus_ack_o) else begin
            $display("Bus access to %h was never acknowledged", addr);
            errors++;
        end
        bus_req_i <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (bus_ack_o && cycles < ACK_LIMIT);
        assert (!bus_ack_o) else begin
            $display("Bus ack to %h stayed high after the request was released", addr);
            errors++;
        end
    endtask

    task automatic bus_read(input addr_t addr, output word_t rdata);
        bus_access(addr, 1'b0, '0, '0, rdata);
    endtask

    // Writes return a zero data word
    task automatic bus_write(input addr_t addr, input word_t wdata, input wmask_t mask);
        word_t write_rdata;
        bus_access(addr, 1'b1, wdata, mask, write_rdata);
        check_word($sformatf("write to %h", addr), write_rdata, '0);
    endtask

    task automatic test_rom();
        word_t got;
        for (int i = 0; i < 16; i++) begin
            bus_read(32'(i * 4), got);
            check_word($sformatf("ROM word %0d", i), got, 32'hC0DE0000 + 32'(i));
            checks++;
            assert (last_latency == 2) else begin
                $display("FAILED %0t ns: ROM word %0d acked after %0d cycles, expected 2",
                         $time, i, last_latency);
                errors++;
            end
        end
        bus_read(32'h0000_0040, got);
        check_word("ROM word 16", got, '0);
    endtask

    task automatic test_ram();
        logic [9:0] word_addr [8];
        word_t      model [8];
        word_t      data;
        word_t      rnd;
        wmask_t     mask;
        int         slot;
        word_t      got;
        // Full-word writes first so that every byte of the model is known
        for (int k = 0; k < 8; k++) begin
            rnd = random_bits(7);
            word_addr[k] = {3'(k), rnd[6:0]};
            data = random_bits(32);
            model[k] = data;
            bus_write(ram_addr(word_addr[k]), data, 4'hF);
        end
        for (int n = 0; n < 16; n++) begin
            rnd = random_bits(3);
            slot = int'(rnd[2:0]);
            data = random_bits(32);
            rnd = random_bits(4);
            mask = rnd[3:0];
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) model[slot][b*8 +: 8] = data[b*8 +: 8];
            end
            bus_write(ram_addr(word_addr[slot]), data, mask);
        end
        for (int k = 0; k < 8; k++) begin
            bus_read(ram_addr(word_addr[k]), got);
            check_word($sformatf("RAM word %h", word_addr[k]), got, model[k]);
        end
        bus_write(32'h0000_0008, 32'hFFFF_FFFF, 4'hF);
        bus_read(32'h0000_0008, got);
        check_word("ROM word 2 after a write", got, 32'hC0DE0002);
    endtask

    task automatic test_kbd();
        word_t got;
        // One more code than the queue holds so the last one is dropped
        for (int i = 0; i < 33; i++) begin
            kbd_code_i   <= 8'h40 + 8'(i);
            kbd_strobe_i <= 1'b1;
            @(posedge clk);
        end
        kbd_strobe_i <= 1'b0;
        @(posedge clk);
        bus_read(KBD_STATUS_ADDR, got);
        check_word("keyboard status when full", got, 32'd1);
        for (int i = 0; i < 32; i++) begin
            bus_write(KBD_STATUS_ADDR, '0, 4'hF);
            bus_read(KBD_CODE_ADDR, got);
            check_word($sformatf("keyboard code %0d", i), got, {24'd0, 8'h40 + 8'(i)});
        end
        bus_read(KBD_STATUS_ADDR, got);
        check_word("keyboard status when empty", got, 32'd0);
        bus_write(KBD_STATUS_ADDR, '0, 4'hF);
        bus_read(KBD_CODE_ADDR, got);
        check_word("keyboard code after empty pop", got, 32'h0000_005F);
    endtask

    task automatic test_usb_display();
        word_t got;
        usb_report_i       <= 64'h1234_5678_9ABC_DEF0;
        usb_report_valid_i <= 1'b1;
        @(posedge clk);
        bus_read(USB_VALID_ADDR, got);
        check_word("USB valid flag", got, 32'd1);
        bus_read(USB_HIGH_ADDR, got);
        check_word("USB high word", got, 32'h1234_5678);
        bus_read(USB_LOW_ADDR, got);
        check_word("USB low word", got, 32'h9ABC_DEF0);
        usb_report_valid_i <= 1'b0;
        @(posedge clk);
        bus_read(USB_VALID_ADDR, got);
        check_word("USB valid flag cleared", got, 32'd0);
        bus_write(DISPLAY_ADDR, 32'hA5A5_A55C, 4'hF);
        check_word("display port", {24'd0, display_o}, 32'h0000_005C);
    endtask

    task automatic test_unmapped();
        word_t got;
        // Region 3 shares its low address bits with RAM word 0x3FF
        bus_write(32'h1000_0FFC, 32'h1357_9BDF, 4'hF);
        bus_read(32'h3000_0FFC, got);
        check_word("region 3", got, '0);
        bus_write(32'h3000_0FFC, 32'hFFFF_FFFF, 4'hF);
        bus_read(32'h2000_7000, got);
        check_word("device select 7", got, '0);
        bus_write(32'h2000_7000, 32'h0000_0077, 4'hF);
        bus_read(32'h3000_0FFC, got);
        check_word("region 3 after a write", got, '0);
        bus_read(32'h1000_0FFC, got);
        check_word("RAM word 3ff", got, 32'h1357_9BDF);
        bus_read(32'h0000_0000, got);
        check_word("ROM word 0", got, 32'hC0DE0000);
        bus_read(KBD_STATUS_ADDR, got);
        check_word("keyboard status", got, 32'd0);
        check_word("display port", {24'd0, display_o}, 32'h0000_005C);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        int start_errors;
        reset_i            = 1'b1;
        bus_req_i          = 1'b0;
        bus_addr_i         = '0;
        bus_we_i           = 1'b0;
        bus_wdata_i        = '0;
        bus_wmask_i        = '0;
        kbd_code_i         = '0;
        kbd_strobe_i       = 1'b0;
        usb_report_i       = '0;
        usb_report_valid_i = 1'b0;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        start_errors = errors;
        test_rom();
        report_test("rom", start_errors);
        start_errors = errors;
        test_ram();
        report_test("ram", start_errors);
        start_errors = errors;
        test_kbd();
        report_test("keyboard queue", start_errors);
        start_errors = errors;
        test_usb_display();
        report_test("usb and display", start_errors);
        start_errors = errors;
        test_unmapped();
        report_test("unmapped", start_errors);
        $display("tests: 5, failed tests: %0d, checks: %0d, errors: %0d",
                 failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog against a bus that never answers
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/soc_fabric_properties.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Req/ack handshake assertions, bound into the fabric top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_properties (
    input wire logic clk,
    input wire logic reset_i,
    input wire logic bus_req_i,
    input wire logic bus_ack_i
);

    ack_low_after_reset: assert property (@(posedge clk) reset_i |=> !bus_ack_i)
        else $error("bus ack high in the cycle after reset");

    // Request must have been seen on the two edges before ack rises
    ack_not_early: assert property (@(posedge clk) disable iff (reset_i)
        $rose(bus_ack_i) |-> $past(bus_req_i, 1) && $past(bus_req_i, 2))
        else $error("bus ack rose less than 2 cycles after the request");

    ack_held: assert property (@(posedge clk) disable iff (reset_i)
        bus_ack_i && bus_req_i |=> bus_ack_i)
        else $error("bus ack dropped while the request was still high");

    ack_released: assert property (@(posedge clk) disable iff (reset_i)
        bus_ack_i && !bus_req_i |=> !bus_ack_i)
        else $error("bus ack did not fall 1 cycle after the request fell");

endmodule

bind soc_fabric soc_fabric_properties i_props (
    .clk(clk), .reset_i(reset_i), .bus_req_i(bus_req_i), .bus_ack_i(bus_ack_o)
);

`default_nettype wire

// ==== source/soc_fabric.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus fabric top with ROM, RAM and device region behind a
// single-master four-phase req/ack bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module soc_fabric import soc_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        bus_req_i,
    input  wire addr_t       bus_addr_i,
    input  wire logic        bus_we_i,
    input  wire word_t       bus_wdata_i,
    input  wire wmask_t      bus_wmask_i,
    output logic             bus_ack_o,
    output word_t            bus_rdata_o,
    input  wire byte_t       kbd_code_i,
    input  wire logic        kbd_strobe_i,
    input  wire usb_report_t usb_report_i,
    input  wire logic        usb_report_valid_i,
    output byte_t            display_o
);

    logic  rom_rd;
    logic  ram_rd;
    logic  ram_we;
    logic  dev_access;
    word_t rom_rdata;
    word_t ram_rdata;
    word_t dev_rdata;
    logic  kbd_pop;
    byte_t kbd_code;
    logic  kbd_empty;

    bus_ctrl i_bus_ctrl (
        .clk(clk), .reset_i(reset_i),
        .bus_req_i(bus_req_i), .bus_region_i(bus_addr_i[31:28]), .bus_we_i(bus_we_i),
        .rom_rdata_i(rom_rdata), .ram_rdata_i(ram_rdata), .dev_rdata_i(dev_rdata),
        .rom_rd_o(rom_rd), .ram_rd_o(ram_rd), .ram_we_o(ram_we),
        .dev_access_o(dev_access),
        .bus_ack_o(bus_ack_o), .bus_rdata_o(bus_rdata_o)
    );

    // Memories are word addressed
    rom_block i_rom (
        .clk(clk), .rd_i(rom_rd), .word_addr_i(bus_addr_i[9:2]), .rdata_o(rom_rdata)
    );

    ram_block i_ram (
        .clk(clk), .rd_i(ram_rd), .we_i(ram_we), .word_addr_i(bus_addr_i[11:2]),
        .wdata_i(bus_wdata_i), .wmask_i(bus_wmask_i), .rdata_o(ram_rdata)
    );

    periph_regs i_periph (
        .clk(clk), .reset_i(reset_i),
        .access_i(dev_access), .we_i(bus_we_i), .dev_offset_i(bus_addr_i[15:0]),
        .wdata_i(bus_wdata_i),
        .usb_report_i(usb_report_i), .usb_report_valid_i(usb_report_valid_i),
        .kbd_code_i(kbd_code), .kbd_empty_i(kbd_empty), .kbd_pop_o(kbd_pop),
        .display_o(display_o), .rdata_o(dev_rdata)
    );

    kbd_queue i_kbd (
        .clk(clk), .reset_i(reset_i),
        .code_i(kbd_code_i), .strobe_i(kbd_strobe_i), .pop_i(kbd_pop),
        .code_o(kbd_code), .empty_o(kbd_empty)
    );

endmodule

`default_nettype wire

// ==== source/kbd_queue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard code FIFO, drops codes that arrive when full
// A pop moves the oldest code into the code register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module kbd_queue import soc_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire byte_t code_i,
    input  wire logic  strobe_i,
    input  wire logic  pop_i,
    output byte_t      code_o,
    output logic       empty_o
);

    localparam int DEPTH = 2 ** KBD_DEPTH_LOG2;

    byte_t mem [DEPTH];

    // One extra pointer bit tells full from empty
    logic [KBD_DEPTH_LOG2:0] wr_ptr;
    logic [KBD_DEPTH_LOG2:0] rd_ptr;
    logic                    full;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[KBD_DEPTH_LOG2] != rd_ptr[KBD_DEPTH_LOG2]) &&
                     (wr_ptr[KBD_DEPTH_LOG2-1:0] == rd_ptr[KBD_DEPTH_LOG2-1:0]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
        end else if (strobe_i && !full) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe_i && !full) begin
            mem[wr_ptr[KBD_DEPTH_LOG2-1:0]] <= code_i;
        end
    end

    // Code register keeps its value on a pop of an empty queue
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ptr <= '0;
            code_o <= '0;
        end else if (pop_i && !empty_o) begin
            code_o <= mem[rd_ptr[KBD_DEPTH_LOG2-1:0]];
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/periph_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Device region registers for display, USB report and keyboard
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module periph_regs import soc_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        access_i,
    input  wire logic        we_i,
    input  wire logic [15:0] dev_offset_i,
    input  wire word_t       wdata_i,
    input  wire usb_report_t usb_report_i,
    input  wire logic        usb_report_valid_i,
    input  wire byte_t       kbd_code_i,
    input  wire logic        kbd_empty_i,
    output logic             kbd_pop_o,
    output byte_t            display_o,
    output word_t            rdata_o
);

    logic [3:0]  dev_sel;
    logic [11:0] reg_off;
    word_t       read_word;

    assign dev_sel = dev_offset_i[15:12];
    assign reg_off = dev_offset_i[11:0];

    // Pop request is dropped when nothing is queued
    assign kbd_pop_o = access_i && we_i && (dev_sel == DEV_KBD) &&
                       (reg_off == 12'h000) && !kbd_empty_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o <= '0;
        end else if (access_i && we_i && (dev_sel == DEV_DISPLAY)) begin
            display_o <= wdata_i[7:0];
        end
    end

    always_comb begin
        read_word = '0;
        if (dev_sel == DEV_KBD) begin
            if (reg_off == 12'h000) read_word = {31'd0, !kbd_empty_i};
            if (reg_off == 12'h004) read_word = {24'd0, kbd_code_i};
        end else if (dev_sel == DEV_USB) begin
            if (reg_off == 12'h000) read_word = {31'd0, usb_report_valid_i};
            if (reg_off == 12'h004) read_word = usb_report_i[63:32];
            if (reg_off == 12'h008) read_word = usb_report_i[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (access_i && !we_i) begin
            rdata_o <= read_word;
        end
    end

endmodule

`default_nettype wire

// ==== source/ram_block.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word RAM with per-byte write mask and registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ram_block import soc_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rd_i,
    input  wire logic                         we_i,
    input  wire logic [$clog2(RAM_WORDS)-1:0] word_addr_i,
    input  wire word_t                        wdata_i,
    input  wire wmask_t                       wmask_i,
    output word_t                             rdata_o
);

    word_t mem [RAM_WORDS];

    // Only bytes with their mask bit set are written
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask_i[b]) begin
                    mem[word_addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_i) begin
            rdata_o <= mem[word_addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== source/rom_block.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-only word memory preloaded from the ROM hex file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rom_block import soc_pkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rd_i,
    input  wire logic [$clog2(ROM_WORDS)-1:0] word_addr_i,
    output word_t                             rdata_o
);

    word_t mem [ROM_WORDS];

    // Words past the end of the hex file read as zero
    initial begin
        for (int i = 0; i < ROM_WORDS; i++) begin
            mem[i] = '0;
        end
        $readmemh(ROM_INIT_FILE, mem);
    end

    always_ff @(posedge clk) begin
        if (rd_i) begin
            rdata_o <= mem[word_addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== source/bus_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase req/ack handshake FSM with region decode
// Issues one access strobe per request and returns read data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl import soc_pkg::*; (
    input  wire logic    clk,
    input  wire logic    reset_i,
    input  wire logic    bus_req_i,
    input  wire region_t bus_region_i,
    input  wire logic    bus_we_i,
    input  wire word_t   rom_rdata_i,
    input  wire word_t   ram_rdata_i,
    input  wire word_t   dev_rdata_i,
    output logic         rom_rd_o,
    output logic         ram_rd_o,
    output logic         ram_we_o,
    output logic         dev_access_o,
    output logic         bus_ack_o,
    output word_t        bus_rdata_o
);

    bus_state_t state_q;
    region_t    region_q;
    logic       we_q;
    logic       start;
    word_t      read_word;
    word_t      rdata_q;

    // A new request is only taken from idle
    assign start = (state_q == BUS_IDLE) && bus_req_i;

    assign rom_rd_o     = start && !bus_we_i && (bus_region_i == REGION_ROM);
    assign ram_rd_o     = start && !bus_we_i && (bus_region_i == REGION_RAM);
    assign ram_we_o     = start && bus_we_i && (bus_region_i == REGION_RAM);
    assign dev_access_o = start && (bus_region_i == REGION_DEV);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= BUS_IDLE;
        end else begin
            case (state_q)
                BUS_IDLE:   if (bus_req_i) state_q <= BUS_ACCESS;
                BUS_ACCESS: state_q <= BUS_DONE;
                BUS_DONE:   if (!bus_req_i) state_q <= BUS_IDLE;
                default:    state_q <= BUS_IDLE;
            endcase
        end
    end

    // Remember what the request was while the datapath answers
    always_ff @(posedge clk) begin
        if (start) begin
            region_q <= bus_region_i;
            we_q     <= bus_we_i;
        end
        if (state_q == BUS_ACCESS) begin
            rdata_q <= read_word;
        end
    end

    // Writes and unmapped regions read as zero
    always_comb begin
        read_word = '0;
        if (!we_q) begin
            case (region_q)
                REGION_ROM: read_word = rom_rdata_i;
                REGION_RAM: read_word = ram_rdata_i;
                REGION_DEV: read_word = dev_rdata_i;
                default:    read_word = '0;
            endcase
        end
    end

    assign bus_ack_o   = (state_q == BUS_DONE);
    assign bus_rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== source/soc_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map, widths and shared types of the bus fabric
// Imported by every fabric module with a wildcard import
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package soc_pkg;

    // Bus and device data types
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  wmask_t;
    typedef logic [7:0]  byte_t;
    typedef logic [63:0] usb_report_t;
    typedef logic [3:0]  region_t;

    // Top address nibble
    localparam region_t REGION_ROM = 4'h0;
    localparam region_t REGION_RAM = 4'h1;
    localparam region_t REGION_DEV = 4'h2;

    // Memory depths in 32-bit words
    localparam int ROM_WORDS = 256;
    localparam int RAM_WORDS = 1024;
    localparam ROM_INIT_FILE = "source/rom_init.hex";

    // Keyboard FIFO holds 2**KBD_DEPTH_LOG2 codes
    localparam int KBD_DEPTH_LOG2 = 5;

    // Device select in address bits 15:12
    localparam logic [3:0] DEV_DISPLAY = 4'h1;
    localparam logic [3:0] DEV_USB     = 4'h4;
    localparam logic [3:0] DEV_KBD     = 4'h5;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ACCESS,
        BUS_DONE
    } bus_state_t;

endpackage

`default_nettype wire
